//--- mipsPkg.sv
package mipsPkg;

   ////////////////////////////////////////////////////////////////////////////
   // word and instruction field types

   typedef logic [31:0] word_t;      // data, address and instruction word
   typedef logic [4:0]  regAddr_t;   // register number
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;

   // opcodes of the supported subset
   localparam opcode_t OP_RTYPE = 6'b000000;
   localparam opcode_t OP_J     = 6'b000010;
   localparam opcode_t OP_BEQ   = 6'b000100;
   localparam opcode_t OP_BNE   = 6'b000101;
   localparam opcode_t OP_ADDI  = 6'b001000;
   localparam opcode_t OP_ANDI  = 6'b001100;
   localparam opcode_t OP_ORI   = 6'b001101;
   localparam opcode_t OP_LUI   = 6'b001111;
   localparam opcode_t OP_LW    = 6'b100011;
   localparam opcode_t OP_SW    = 6'b101011;

   // R-type funct codes
   localparam funct_t FN_ADD = 6'b100000;
   localparam funct_t FN_SUB = 6'b100010;
   localparam funct_t FN_OR  = 6'b100101;

   ////////////////////////////////////////////////////////////////////////////
   // control encodings

   // operation the ALU actually performs
   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_LUI} aluFn_t;

   // operation requested by the FSM, funct decides for R-type
   typedef enum logic [2:0] {
      AOP_ADD, AOP_SUB, AOP_AND, AOP_OR, AOP_LUI, AOP_FUNCT
   } aluOp_t;

   typedef enum logic [3:0] {
      FETCH, DECODE, MEMADR, MEMRD, MEMWB, MEMWR,
      REXEC, IEXEC, ALUWB, BRANCH, JUMP
   } cpuState_t;

   // second ALU operand
   typedef enum logic [2:0] {
      SRCB_REG, SRCB_FOUR, SRCB_SEXT, SRCB_ZEXT, SRCB_BROFS
   } srcB_t;

   // next pc source
   typedef enum logic [1:0] {PC_ALU, PC_BRANCH, PC_JUMP} pcSrc_t;

   localparam word_t RESET_PC = 32'h0000_0000;

endpackage

//--- ctrlIf.sv
`timescale 1ns/100ps

interface ctrlIf;
   import mipsPkg::*;

   logic   pcWrite, branchEq, branchNe;
   pcSrc_t pcSrc;
   logic   irWrite;
   logic   regWrite, regDst, memToReg;
   logic   aluSrcA;          // 0 pc, 1 register A
   srcB_t  srcB;
   aluOp_t aluOp;
   logic   iOrD;             // 0 fetch address, 1 data address
   logic   memStart, memWe;
   logic   memDone;          // returned by the memory port

   modport control (output pcWrite, branchEq, branchNe, pcSrc, irWrite, regWrite, regDst,
                    memToReg, aluSrcA, srcB, aluOp, iOrD, memStart, memWe,
                    input memDone);
   modport datapath (input pcWrite, branchEq, branchNe, pcSrc, irWrite, regWrite, regDst,
                     memToReg, aluSrcA, srcB, aluOp, iOrD, memStart, memWe,
                     output memDone);

endinterface

//--- mipsControl.sv
`timescale 1ns/100ps

module mipsControl (
   input  logic           clk,
   input  logic           reset,
   input  mipsPkg::word_t instr,
   ctrlIf.control         ctrl
);
   import mipsPkg::*;

   cpuState_t state;
   cpuState_t nextState;
   opcode_t   opcode;
   logic      stateEntry;   // first cycle in the current state
   logic      accessBusy;   // access issued and memDone not yet seen

   assign opcode = instr[31:26];

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= FETCH;
      else
         state <= nextState;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         stateEntry <= 1'b1;
      else
         stateEntry <= (nextState != state);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         accessBusy <= 1'b0;
      else if (ctrl.memStart)
         accessBusy <= 1'b1;
      else if (ctrl.memDone)
         accessBusy <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // next state

   always_comb
   begin
      nextState = state;
      case (state)
         FETCH:   if (ctrl.memDone) nextState = DECODE;
         DECODE:
            case (opcode)
               OP_LW, OP_SW:                      nextState = MEMADR;
               OP_RTYPE:                          nextState = REXEC;
               OP_ADDI, OP_ANDI, OP_ORI, OP_LUI:  nextState = IEXEC;
               OP_BEQ, OP_BNE:                    nextState = BRANCH;
               OP_J:                              nextState = JUMP;
               default:                           nextState = FETCH;  // unknown opcode
            endcase
         MEMADR:  nextState = (opcode == OP_LW) ? MEMRD : MEMWR;
         MEMRD:   if (ctrl.memDone) nextState = MEMWB;
         MEMWR:   if (ctrl.memDone) nextState = FETCH;
         REXEC,
         IEXEC:   nextState = ALUWB;
         default: nextState = FETCH;   // MEMWB, ALUWB, BRANCH, JUMP
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // strobes and selects stay inactive unless the state asks for them

   always_comb
   begin
      ctrl.pcWrite  = 1'b0;
      ctrl.branchEq = 1'b0;
      ctrl.branchNe = 1'b0;
      ctrl.pcSrc    = PC_ALU;
      ctrl.irWrite  = 1'b0;
      ctrl.regWrite = 1'b0;
      ctrl.regDst   = 1'b0;
      ctrl.memToReg = 1'b0;
      ctrl.aluSrcA  = 1'b0;
      ctrl.srcB     = SRCB_REG;
      ctrl.aluOp    = AOP_ADD;
      ctrl.iOrD     = 1'b0;
      ctrl.memStart = 1'b0;
      ctrl.memWe    = 1'b0;
      case (state)
         FETCH:
         begin
            ctrl.memStart = stateEntry;
            ctrl.srcB     = SRCB_FOUR;        // pc + 4 on the done cycle
            ctrl.irWrite  = ctrl.memDone;
            ctrl.pcWrite  = ctrl.memDone;
         end
         DECODE:  ctrl.srcB = SRCB_BROFS;  // branch target into aluOut
         MEMADR:
         begin
            ctrl.aluSrcA = 1'b1;
            ctrl.srcB    = SRCB_SEXT;
         end
         MEMRD:
         begin
            ctrl.iOrD     = 1'b1;
            ctrl.memStart = stateEntry;
         end
         MEMWB:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
         end
         MEMWR:
         begin
            ctrl.iOrD     = 1'b1;
            ctrl.memWe    = 1'b1;
            ctrl.memStart = stateEntry;
         end
         REXEC:
         begin
            ctrl.aluSrcA = 1'b1;
            ctrl.aluOp   = AOP_FUNCT;
         end
         IEXEC:
         begin
            ctrl.aluSrcA = 1'b1;
            ctrl.srcB    = (opcode == OP_ADDI) ? SRCB_SEXT : SRCB_ZEXT;
            case (opcode)
               OP_ANDI: ctrl.aluOp = AOP_AND;
               OP_ORI:  ctrl.aluOp = AOP_OR;
               OP_LUI:  ctrl.aluOp = AOP_LUI;
               default: ctrl.aluOp = AOP_ADD;
            endcase
         end
         ALUWB:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = (opcode == OP_RTYPE);   // rd for R-type and rt otherwise
         end
         BRANCH:
         begin
            ctrl.aluSrcA  = 1'b1;
            ctrl.aluOp    = AOP_SUB;                // compare via zero flag
            ctrl.pcSrc    = PC_BRANCH;
            ctrl.branchEq = (opcode == OP_BEQ);
            ctrl.branchNe = (opcode == OP_BNE);
         end
         JUMP:
         begin
            ctrl.pcWrite = 1'b1;
            ctrl.pcSrc   = PC_JUMP;
         end
         default: ;
      endcase
   end

   // one access at a time across the control and the memory port
   assert property (@(posedge clk) disable iff (reset)
      ctrl.memStart |-> !accessBusy);

endmodule

//--- instrPath.sv
`timescale 1ns/100ps

module instrPath (
   input  logic           clk,
   input  logic           reset,
   ctrlIf.datapath        ctrl,
   input  logic           zero,
   input  mipsPkg::word_t aluResult,
   input  mipsPkg::word_t aluOut,
   input  mipsPkg::word_t memData,
   output mipsPkg::word_t pc,
   output mipsPkg::word_t instr
);
   import mipsPkg::*;

   word_t jumpTarget;
   word_t nextPc;
   logic  branchTaken;
   logic  pcEn;

   // pc holds pc + 4 by now, so its top nibble is the jump region
   assign jumpTarget = {pc[31:28], instr[25:0], 2'b00};

   assign branchTaken = (ctrl.branchEq && zero) || (ctrl.branchNe && !zero);
   assign pcEn        = ctrl.pcWrite || branchTaken;

   always_comb
   begin
      case (ctrl.pcSrc)
         PC_BRANCH: nextPc = aluOut;      // target computed in decode
         PC_JUMP:   nextPc = jumpTarget;
         default:   nextPc = aluResult;   // sequential pc + 4
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // program counter and instruction register

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= RESET_PC;
      else if (pcEn)
         pc <= nextPc;
   end

   always_ff @(posedge clk)
   begin
      if (ctrl.irWrite)
         instr <= memData;   // fetched word from the memory port
   end

endmodule

//--- regFile.sv
`timescale 1ns/100ps

module regFile #(
   parameter int WIDTH   = 32,
   parameter int REGBITS = 32     // number of registers
) (
   input  logic           clk,
   input  logic           reset,
   ctrlIf.datapath        ctrl,
   input  mipsPkg::word_t instr,
   input  mipsPkg::word_t aluOut,
   input  mipsPkg::word_t memData,
   output mipsPkg::word_t rd1,
   output mipsPkg::word_t rd2
);
   import mipsPkg::*;

   localparam int ADDRW = $clog2(REGBITS);

   logic [WIDTH-1:0] regs [REGBITS];
   regAddr_t         rs, rt, rd;
   logic [ADDRW-1:0] wa;
   logic [WIDTH-1:0] wd;

   assign rs = instr[25:21];
   assign rt = instr[20:16];
   assign rd = instr[15:11];

   assign wa = ctrl.regDst ? rd[ADDRW-1:0] : rt[ADDRW-1:0];
   assign wd = ctrl.memToReg ? memData : aluOut;   // load data or alu result

   always_ff @(posedge clk)
   begin
      if (reset)
         for (int i = 0; i < REGBITS; i++)
            regs[i] <= '0;
      else if (ctrl.regWrite && wa != '0)
         regs[wa] <= wd;   // register 0 keeps its reset value
   end

   assign rd1 = regs[rs[ADDRW-1:0]];
   assign rd2 = regs[rt[ADDRW-1:0]];

   // a write aimed at register 0 must not show up on the read ports
   assert property (@(posedge clk) disable iff (reset)
      (ctrl.regWrite && wa == '0) |=> ((rs != '0 || rd1 == '0) && (rt != '0 || rd2 == '0)));

endmodule

//--- aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
   input  logic           clk,
   ctrlIf.datapath        ctrl,
   input  mipsPkg::word_t instr,
   input  mipsPkg::word_t pc,
   input  mipsPkg::word_t rd1,
   input  mipsPkg::word_t rd2,
   output mipsPkg::word_t aluResult,
   output mipsPkg::word_t aluOut,
   output logic           zero
);
   import mipsPkg::*;

   word_t  aReg, bReg;
   word_t  opA, opB;
   word_t  signImm, zeroImm, branchOfs;
   funct_t funct;
   aluFn_t aluFn;

   assign funct     = instr[5:0];
   assign signImm   = {{16{instr[15]}}, instr[15:0]};
   assign zeroImm   = {16'h0000, instr[15:0]};
   assign branchOfs = {signImm[29:0], 2'b00};   // word offset to bytes

   ////////////////////////////////////////////////////////////////////////////
   // operand selection

   assign opA = ctrl.aluSrcA ? aReg : pc;

   always_comb
   begin
      case (ctrl.srcB)
         SRCB_FOUR:  opB = 32'd4;
         SRCB_SEXT:  opB = signImm;
         SRCB_ZEXT:  opB = zeroImm;
         SRCB_BROFS: opB = branchOfs;
         default:    opB = bReg;
      endcase
   end

   always_comb
   begin
      case (ctrl.aluOp)
         AOP_SUB:   aluFn = ALU_SUB;
         AOP_AND:   aluFn = ALU_AND;
         AOP_OR:    aluFn = ALU_OR;
         AOP_LUI:   aluFn = ALU_LUI;
         AOP_FUNCT:
            case (funct)
               FN_SUB:  aluFn = ALU_SUB;
               FN_OR:   aluFn = ALU_OR;
               default: aluFn = ALU_ADD;   // FN_ADD and anything unknown
            endcase
         default:   aluFn = ALU_ADD;
      endcase
   end

   always_comb
   begin
      case (aluFn)
         ALU_SUB: aluResult = opA - opB;
         ALU_AND: aluResult = opA & opB;
         ALU_OR:  aluResult = opA | opB;
         ALU_LUI: aluResult = opB << 16;
         default: aluResult = opA + opB;
      endcase
   end

   assign zero = (aluResult == '0);

   always_ff @(posedge clk)
   begin
      aReg   <= rd1;
      bReg   <= rd2;
      aluOut <= aluResult;
   end

endmodule

//--- memPort.sv
`timescale 1ns/100ps

module memPort #(
   parameter int WIDTH = 32
) (
   input  logic           clk,
   input  logic           reset,
   ctrlIf.datapath        ctrl,
   input  mipsPkg::word_t pc,
   input  mipsPkg::word_t aluOut,
   input  mipsPkg::word_t rd2,
   output mipsPkg::word_t memData,
   output logic           memReq,
   output logic           memWe,
   output mipsPkg::word_t memAddr,
   output mipsPkg::word_t memWdata,
   input  logic           memAck,
   input  mipsPkg::word_t memRdata
);
   import mipsPkg::*;

   typedef enum logic [1:0] {PH_IDLE, PH_REQ, PH_RELEASE} memPhase_t;

   memPhase_t        phase;
   logic             doneReg;
   logic [WIDTH-1:0] addrReg, wdataReg, rdataReg;

   ////////////////////////////////////////////////////////////////////////////
   // four-phase handshake master

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase   <= PH_IDLE;
         memReq  <= 1'b0;
         memWe   <= 1'b0;
         doneReg <= 1'b0;
      end
      else
      begin
         doneReg <= 1'b0;
         case (phase)
            PH_IDLE:
               if (ctrl.memStart)
               begin
                  phase  <= PH_REQ;
                  memReq <= 1'b1;
                  memWe  <= ctrl.memWe;
               end
            PH_REQ:
               if (memAck)
               begin
                  phase  <= PH_RELEASE;
                  memReq <= 1'b0;
                  memWe  <= 1'b0;
               end
            default:
               if (!memAck)
               begin
                  phase   <= PH_IDLE;
                  doneReg <= 1'b1;   // pulse once ack is back low
               end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (phase == PH_IDLE && ctrl.memStart)
      begin
         addrReg  <= ctrl.iOrD ? aluOut : pc;
         wdataReg <= rd2;
      end
      if (phase == PH_REQ && memAck && !memWe)
         rdataReg <= memRdata;   // same edge that drops the request
   end

   assign memAddr      = addrReg;
   assign memWdata     = wdataReg;
   assign memData      = rdataReg;
   assign ctrl.memDone = doneReg;

   assert property (@(posedge clk) disable iff (reset)
      memReq |=> (!memReq || ($stable(memAddr) && $stable(memWdata))));

   // request only rises after ack was seen low
   assert property (@(posedge clk) disable iff (reset)
      $rose(memReq) |-> !$past(memAck));

endmodule

//--- mipsTop.sv
`timescale 1ns/100ps

module mipsTop #(
   parameter int WIDTH   = 32,
   parameter int REGBITS = 32
) (
   input  logic           clk,
   input  logic           reset,
   output logic           memReq,
   output logic           memWe,
   output mipsPkg::word_t memAddr,
   output mipsPkg::word_t memWdata,
   input  logic           memAck,
   input  mipsPkg::word_t memRdata
);
   import mipsPkg::*;

   word_t instr, pc;
   word_t aluResult, aluOut;
   word_t rd1, rd2;
   word_t memData;
   logic  zero;

   ctrlIf ctrl ();

   mipsControl u_control (
      .clk   (clk),
      .reset (reset),
      .instr (instr),
      .ctrl  (ctrl.control)
   );

   instrPath u_instrPath (
      .clk       (clk),
      .reset     (reset),
      .ctrl      (ctrl.datapath),
      .zero      (zero),
      .aluResult (aluResult),
      .aluOut    (aluOut),
      .memData   (memData),
      .pc        (pc),
      .instr     (instr)
   );

   regFile #(.WIDTH(WIDTH), .REGBITS(REGBITS)) u_regFile (
      .clk     (clk),
      .reset   (reset),
      .ctrl    (ctrl.datapath),
      .instr   (instr),
      .aluOut  (aluOut),
      .memData (memData),
      .rd1     (rd1),
      .rd2     (rd2)
   );

   aluUnit u_aluUnit (
      .clk       (clk),
      .ctrl      (ctrl.datapath),
      .instr     (instr),
      .pc        (pc),
      .rd1       (rd1),
      .rd2       (rd2),
      .aluResult (aluResult),
      .aluOut    (aluOut),
      .zero      (zero)
   );

   memPort #(.WIDTH(WIDTH)) u_memPort (
      .clk      (clk),
      .reset    (reset),
      .ctrl     (ctrl.datapath),
      .pc       (pc),
      .aluOut   (aluOut),
      .rd2      (rd2),
      .memData  (memData),
      .memReq   (memReq),
      .memWe    (memWe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memAck   (memAck),
      .memRdata (memRdata)
   );

endmodule

//--- tbModel.svh
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

////////////////////////////////////////////////////////////////////////////
// random source

word_t lfsrState = 32'd78447;

// galois form, one step for every bit handed out
function automatic logic takeBit();
   logic outBit;
   outBit    = lfsrState[0];
   lfsrState = lfsrState >> 1;
   if (outBit)
      lfsrState = lfsrState ^ 32'hD000_0001;
   return outBit;
endfunction

function automatic int takeBits(input int n);
   int value;
   value = 0;
   for (int i = 0; i < n; i++)
      value = (value << 1) | int'(takeBit());
   return value;
endfunction

// background word, differs at every address
function automatic word_t fillWord(input int idx);
   return (32'(idx) * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
endfunction

////////////////////////////////////////////////////////////////////////////
// random program

word_t prog [PROG_LEN];

function automatic word_t encodeI(input opcode_t op, input int rs, input int rt, input int imm);
   return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic word_t encodeR(input funct_t fn, input int rs, input int rt, input int rd);
   return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic void genProgram();
   int kind, rs, rt, rd, tgt;
   for (int i = 0; i < RAND_LEN; i++)
   begin
      kind = takeBits(4);
      rs   = takeBits(3);        // registers 0 to 7 only
      rt   = takeBits(3);
      rd   = takeBits(3);
      tgt  = i + 1 + takeBits(3);   // forward only
      if (tgt > RAND_LEN)
         tgt = RAND_LEN;
      case (kind)
         0:       prog[i] = encodeR(FN_ADD, rs, rt, rd);
         1:       prog[i] = encodeR(FN_SUB, rs, rt, rd);
         2:       prog[i] = encodeR(FN_OR, rs, rt, rd);
         3, 14:   prog[i] = encodeI(OP_ADDI, rs, rt, takeBits(16));
         4:       prog[i] = encodeI(OP_ANDI, rs, rt, takeBits(16));
         5, 15:   prog[i] = encodeI(OP_ORI, rs, rt, takeBits(16));
         6:       prog[i] = encodeI(OP_LUI, 0, rt, takeBits(16));
         7, 12:   prog[i] = encodeI(OP_LW, 0, rt, DATA_BASE + 4 * takeBits(4));
         8, 13:   prog[i] = encodeI(OP_SW, 0, rt, DATA_BASE + 4 * takeBits(4));
         9:       prog[i] = encodeI(OP_BEQ, rs, rt, tgt - i - 1);
         10:      prog[i] = encodeI(OP_BNE, rs, rt, tgt - i - 1);
         default: prog[i] = {OP_J, 26'(tgt)};
      endcase
   end
   // dump r1..r7, then spin on the last word
   for (int r = 1; r < 8; r++)
      prog[RAND_LEN + r - 1] = encodeI(OP_SW, 0, r, DUMP_BASE + 4 * (r - 1));
   prog[PROG_LEN - 1] = {OP_J, 26'(PROG_LEN - 1)};
endfunction

////////////////////////////////////////////////////////////////////////////
// reference model, expected bus accesses in order

int    expKind [$];
word_t expAddr [$];
word_t expData [$];
word_t refMem  [MEM_WORDS];

function automatic void expectAccess(input int kind, input word_t addr, input word_t data);
   expKind.push_back(kind);
   expAddr.push_back(addr);
   expData.push_back(data);
endfunction

function automatic void runModel();
   word_t regs [32];
   word_t ins, a, b, sImm, zImm, addr;
   int    pcIdx, nextIdx;
   bit    halted;
   expKind.delete();
   expAddr.delete();
   expData.delete();
   foreach (regs[r])
      regs[r] = '0;
   pcIdx  = 0;
   halted = 1'b0;
   while (!halted && pcIdx < PROG_LEN)
   begin
      ins     = prog[pcIdx];
      a       = regs[ins[25:21]];
      b       = regs[ins[20:16]];
      sImm    = {{16{ins[15]}}, ins[15:0]};
      zImm    = {16'h0000, ins[15:0]};
      addr    = a + sImm;
      nextIdx = pcIdx + 1;
      expectAccess(KIND_FETCH, 32'(pcIdx * 4), '0);
      case (ins[31:26])
         OP_RTYPE:
            case (ins[5:0])
               FN_SUB:  regs[ins[15:11]] = a - b;
               FN_OR:   regs[ins[15:11]] = a | b;
               default: regs[ins[15:11]] = a + b;
            endcase
         OP_ADDI: regs[ins[20:16]] = addr;
         OP_ANDI: regs[ins[20:16]] = a & zImm;
         OP_ORI:  regs[ins[20:16]] = a | zImm;
         OP_LUI:  regs[ins[20:16]] = {ins[15:0], 16'h0000};
         OP_LW:
         begin
            expectAccess(KIND_LOAD, addr, '0);
            regs[ins[20:16]] = refMem[addr[12:2]];
         end
         OP_SW:
         begin
            expectAccess(KIND_STORE, addr, b);
            refMem[addr[12:2]] = b;
         end
         OP_BEQ: if (a == b) nextIdx = pcIdx + 1 + int'($signed(ins[15:0]));
         OP_BNE: if (a != b) nextIdx = pcIdx + 1 + int'($signed(ins[15:0]));
         OP_J:
         begin
            nextIdx = int'(ins[25:0]);
            halted  = (nextIdx == pcIdx);   // jump to itself
         end
         default: ;
      endcase
      regs[0] = '0;
      pcIdx   = nextIdx;
   end
endfunction

`endif

//--- tbMips.sv
`timescale 1ns/100ps

module tbMips;
   import mipsPkg::*;

   localparam int NUM_TESTS      = 8;
   localparam int RAND_LEN       = 40;
   localparam int PROG_LEN       = 48;
   localparam int MEM_WORDS      = 2048;   // 8 KB with text at 0 and data at 0x1000
   localparam int DATA_BASE      = 32'h1000;
   localparam int DUMP_BASE      = 32'h1040;
   localparam int KIND_FETCH     = 0;
   localparam int KIND_LOAD      = 1;
   localparam int KIND_STORE     = 2;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * PROG_LEN * (4 + 2 * 9);

   logic  clk;
   logic  reset;
   logic  memReq, memWe, memAck;
   word_t memAddr, memWdata, memRdata;

   word_t mem [MEM_WORDS];
   int    errorCount;
   int    checkCount;
   int    cycleCount;

   logic  ackSeen, resetSeen;      // inputs as the DUT saw them at the rising edge
   logic  prevReq;
   word_t prevAddr, prevWdata;

   `include "tbModel.svh"

   mipsTop #(.WIDTH(32), .REGBITS(32)) u_dut (
      .clk      (clk),
      .reset    (reset),
      .memReq   (memReq),
      .memWe    (memWe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memAck   (memAck),
      .memRdata (memRdata)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display(">>> FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // handshake monitor

   always @(posedge clk)
   begin
      ackSeen   <= memAck;
      resetSeen <= reset;
   end

   always @(negedge clk)
   begin
      if (!resetSeen && memReq && !prevReq && ackSeen)
      begin
         $display("ERROR at %0t: memReq rose while memAck was still high", $time);
         errorCount++;
      end
      if (!resetSeen && memReq && prevReq && (memAddr !== prevAddr || memWdata !== prevWdata))
      begin
         $display("ERROR at %0t: address or write data changed during a request", $time);
         errorCount++;
      end
      prevReq   <= memReq;
      prevAddr  <= memAddr;
      prevWdata <= memWdata;
   end

   ////////////////////////////////////////////////////////////////////////////
   // compare tasks

   task automatic compareWord(input string name, input word_t expected, input word_t actual);
      checkCount++;
      if (actual !== expected)
      begin
         $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                  $time, name, expected, actual);
         errorCount++;
      end
   endtask

   task automatic checkAddr(input word_t expected, input word_t actual);
      compareWord("memAddr (fetch)", expected, actual);
   endtask

   task automatic checkLoad(input word_t expected, input word_t actual);
      compareWord("memAddr (load)", expected, actual);
   endtask

   task automatic checkStore(input word_t expAddr, input word_t expData,
                             input word_t actAddr, input word_t actData);
      compareWord("memAddr (store)", expAddr, actAddr);
      compareWord("memWdata", expData, actData);
   endtask

   // memory side of one four-phase transfer starting on a falling edge
   task automatic serveAccess(output logic isWrite, output word_t addr, output word_t wdata,
                              output int waitCycles);
      int delay;
      waitCycles = 0;
      while (memReq !== 1'b1)
      begin
         @(negedge clk);
         waitCycles++;
      end
      isWrite = memWe;
      addr    = memAddr;
      wdata   = memWdata;
      delay   = takeBits(2);
      repeat (delay) @(negedge clk);
      if (isWrite)
         mem[addr[12:2]] = wdata;
      else
         memRdata = mem[addr[12:2]];
      memAck = 1'b1;
      while (memReq === 1'b1)
         @(negedge clk);
      delay = takeBits(2);
      repeat (delay) @(negedge clk);
      memAck   = 1'b0;
      memRdata = '0;
   endtask

   task automatic applyReset();
      reset  = 1'b1;
      memAck = 1'b0;
      repeat (4) @(negedge clk);
      if (memReq !== 1'b0 || memWe !== 1'b0)
      begin
         $display("ERROR at %0t: memReq or memWe is not low in reset", $time);
         errorCount++;
      end
      reset = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence

   initial
   begin
      logic  isWrite;
      word_t addr, wdata, eAddr, eData;
      int    waitCycles, kind, accesses, testErrors;
      clk        = 1'b0;
      reset      = 1'b1;
      memAck     = 1'b0;
      memRdata   = '0;
      errorCount = 0;
      checkCount = 0;
      cycleCount = 0;
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         genProgram();
         foreach (mem[i])
            mem[i] = fillWord(i);
         foreach (prog[i])
            mem[i] = prog[i];
         refMem = mem;
         runModel();
         testErrors = errorCount;
         applyReset();
         accesses   = 0;
         while (expKind.size() > 0)   // last one is the halt fetch
         begin
            serveAccess(isWrite, addr, wdata, waitCycles);
            kind  = expKind.pop_front();
            eAddr = expAddr.pop_front();
            eData = expData.pop_front();
            if (accesses == 0 && waitCycles > 2)
            begin
               $display("ERROR at %0t: first request came %0d cycles after reset",
                        $time, waitCycles);
               errorCount++;
            end
            if (isWrite !== (kind == KIND_STORE))
            begin
               $display("ERROR at %0t: bus access %0d of test %0d went the wrong way",
                        $time, accesses, t);
               errorCount++;
            end
            else if (kind == KIND_FETCH)
               checkAddr(eAddr, addr);
            else if (kind == KIND_LOAD)
               checkLoad(eAddr, addr);
            else
               checkStore(eAddr, eData, addr, wdata);
            accesses++;
         end
         $display("test %0d: %0d bus accesses, %0d errors", t, accesses,
                  errorCount - testErrors);
      end
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checkCount, errorCount);
      if (errorCount == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+.
mipsPkg.sv
ctrlIf.sv
mipsControl.sv
instrPath.sv
regFile.sv
aluUnit.sv
memPort.sv
mipsTop.sv
tbMips.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbMips -f filelist.f -o simMips \
   && ./obj_dir/simMips > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q '^>>> PASS$' sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
